/* l2_pkg.sv */
// Common widths, ids and entry formats for the L1 to L2 request path
// Data cache must stay at index 0 because the arbiter relies on its priority
// Burst size counts words minus one and is ignored on writes
package l2_pkg;

    //////////////////////////////
    // Requesters
    localparam int L1_CONNECTIONS = 2;
    localparam int L1_DCACHE_ID = 0;
    localparam int L1_ICACHE_ID = 1;
    // Index width out of the encoder
    localparam int L1_SEL_W = (L1_CONNECTIONS == 1) ? 1 : $clog2(L1_CONNECTIONS);
    localparam int L2_SUB_ID_W = 1;

    //////////////////////////////
    // Data path and memory
    localparam int XLEN = 32;
    localparam int BE_W = XLEN / 8;
    localparam int MEM_ADDR_W = 8;
    localparam int MEM_DEPTH = 1 << MEM_ADDR_W;
    localparam int BURST_W = 2;

    // Queue sizes
    localparam int REQ_FIFO_DEPTH = 4;
    localparam int DATA_FIFO_DEPTH = 4;

    // Backend sequencer states
    typedef enum logic [1:0] {
        MEM_IDLE    = 2'd0,
        MEM_LATENCY = 2'd1,
        MEM_BURST   = 2'd2
    } mem_state_t;

    //////////////////////////////
    // Request formats
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic rnw;
        logic [BURST_W-1:0] size;
        logic [XLEN-1:0] data;
        logic [BE_W-1:0] be;
    } l1_request_t;

    // Word address, byte offset already dropped
    typedef struct packed {
        logic [XLEN-3:0] addr;
        logic rnw;
        logic [BURST_W-1:0] burst_size;
        logic [L2_SUB_ID_W-1:0] sub_id;
    } l2_request_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic [BE_W-1:0] be;
    } l2_wr_data_t;

endpackage

/* priority_encoder.sv */
// Fixed priority, lowest set bit wins
// An all-zero vector gives index 0, so callers must gate on any request
`timescale 1ns/1ps

module priority_encoder
    import l2_pkg::*;
(
    input  logic [L1_CONNECTIONS-1:0] priority_vector,
    output logic [L1_SEL_W-1:0]       encoded_result
);

    // Scan from the top down so the lowest set index is written last
    always_comb begin
        encoded_result = '0;
        for (int i = L1_CONNECTIONS - 1; i >= 0; i--) begin
            if (priority_vector[i]) begin
                encoded_result = L1_SEL_W'(i);
            end
        end
    end

endmodule

/* l2_fifo.sv */
// Synchronous FIFO, head entry visible the cycle after its push
// DEPTH must be 2 or more; storage is not cleared by reset
// Push while full is taken only together with a pop
`timescale 1ns/1ps

module l2_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head_data,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] storage [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic push_ok;
    logic pop_ok;

    // Pop of an empty queue is dropped
    assign pop_ok = pop & ~empty;
    // Full queue still takes a push when the head leaves in the same cycle
    assign push_ok = push & (~full | pop);

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign head_data = storage[rd_ptr];

    //////////////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            storage[wr_ptr] <= push_data;
        end
    end

endmodule

/* l1_arbiter.sv */
// Combinational arbiter between the L1 caches and the L2 queues
// Only the data cache may write, and it must hold the top priority
// Return data is always accepted, there is no stall on that side
`timescale 1ns/1ps

module l1_arbiter
    import l2_pkg::*;
(
    input  l1_request_t [L1_CONNECTIONS-1:0] l1_req,
    input  logic [L1_CONNECTIONS-1:0]        request,
    output logic [L1_CONNECTIONS-1:0]        ack,

    input  logic                             req_full,
    input  logic                             data_full,
    output logic                             req_push,
    output l2_request_t                      l2_req,
    output logic                             wr_push,
    output l2_wr_data_t                      wr_data,

    input  logic                             rd_valid,
    input  logic [XLEN-1:0]                  rd_data,
    input  logic [L2_SUB_ID_W-1:0]           rd_sub_id,
    output logic [XLEN-1:0]                  l1_rd_data,
    output logic [L1_CONNECTIONS-1:0]        data_valid
);

    l2_request_t [L1_CONNECTIONS-1:0] l2_requests;
    logic [L1_SEL_W-1:0] arb_sel;
    logic push_ready;

    //////////////////////////////
    // Request mapping
    // Word address, burst length and requester tag per port
    always_comb begin
        for (int i = 0; i < L1_CONNECTIONS; i++) begin
            l2_requests[i].addr = l1_req[i].addr[XLEN-1:2];
            l2_requests[i].rnw = l1_req[i].rnw;
            l2_requests[i].burst_size = l1_req[i].size;
            l2_requests[i].sub_id = L2_SUB_ID_W'(i);
        end
    end

    //////////////////////////////
    // Arbitration
    priority_encoder u_encoder (
        .priority_vector (request),
        .encoded_result  (arb_sel)
    );

    // Both queues need room so they stay in step
    assign push_ready = ~(req_full | data_full);
    assign req_push = push_ready & (|request);
    assign l2_req = l2_requests[arb_sel];

    // Ack pulse to the winner only
    always_comb begin
        ack = '0;
        ack[arb_sel] = req_push;
    end

    // Store word goes out with its request
    // Dcache wins whenever it asks, so its write is the pushed one
    assign wr_push = push_ready & request[L1_DCACHE_ID] & ~l1_req[L1_DCACHE_ID].rnw;
    assign wr_data.data = l1_req[L1_DCACHE_ID].data;
    assign wr_data.be = l1_req[L1_DCACHE_ID].be;

    //////////////////////////////
    // Return routing
    // Shared data bus, valid steered by sub-id
    assign l1_rd_data = rd_data;

    always_comb begin
        for (int i = 0; i < L1_CONNECTIONS; i++) begin
            data_valid[i] = rd_valid && (rd_sub_id == L2_SUB_ID_W'(i));
        end
    end

endmodule

/* l2_memory.sv */
// Single-port L2 backend, 256 words, drains both queues in order
// Contents are undefined until written; no clear at reset
// Reads return burst_size+1 words, first word two cycles after the pop
// Writes are one word with byte enables, applied at the pop edge
`timescale 1ns/1ps

module l2_memory
    import l2_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  l2_request_t            req_head,
    input  logic                   req_empty,
    output logic                   req_pop,
    input  l2_wr_data_t            wr_head,
    output logic                   wr_pop,

    output logic                   rd_valid,
    output logic [XLEN-1:0]        rd_data,
    output logic [L2_SUB_ID_W-1:0] rd_sub_id
);

    logic [XLEN-1:0] mem [MEM_DEPTH];

    mem_state_t state;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic [MEM_ADDR_W-1:0] wr_idx;
    logic [BURST_W-1:0] burst_left;
    logic [L2_SUB_ID_W-1:0] sub_id_r;
    logic rd_issue;
    logic rd_start;

    //////////////////////////////
    // Queue pops
    // Take a new request only when idle
    assign req_pop = (state == MEM_IDLE) && !req_empty;
    // Write data leaves with its request
    assign wr_pop = req_pop && !req_head.rnw;
    assign rd_start = req_pop && req_head.rnw;

    // Low word bits index the array
    assign wr_idx = req_head.addr[MEM_ADDR_W-1:0];

    // One array read per cycle while a burst is running
    assign rd_issue = (state == MEM_LATENCY) || (state == MEM_BURST);

    //////////////////////////////
    // Sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MEM_IDLE;
            rd_valid <= 1'b0;
        end else begin
            // Registered read port, valid trails the issue by one
            rd_valid <= rd_issue;
            case (state)
                MEM_IDLE: begin
                    if (rd_start) begin
                        state <= MEM_LATENCY;
                    end
                end
                // First word read here
                MEM_LATENCY: begin
                    state <= (burst_left == '0) ? MEM_IDLE : MEM_BURST;
                end
                // Last word when one remains
                MEM_BURST: begin
                    if (burst_left == BURST_W'(1)) begin
                        state <= MEM_IDLE;
                    end
                end
                default: begin
                    state <= MEM_IDLE;
                end
            endcase
        end
    end

    // Burst bookkeeping, loaded at every read pop
    always_ff @(posedge clk) begin
        if (rd_start) begin
            rd_addr <= wr_idx;
            burst_left <= req_head.burst_size;
            sub_id_r <= req_head.sub_id;
        end else if (rd_issue) begin
            // Wraps inside the array
            rd_addr <= rd_addr + 1'b1;
            if (state == MEM_BURST) begin
                burst_left <= burst_left - 1'b1;
            end
        end
    end

    //////////////////////////////
    // Storage
    // Reads and writes never share a cycle, the write only pops when idle
    always_ff @(posedge clk) begin
        if (wr_pop) begin
            for (int b = 0; b < BE_W; b++) begin
                if (wr_head.be[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wr_head.data[b*8 +: 8];
                end
            end
        end
        if (rd_issue) begin
            rd_data <= mem[rd_addr];
            rd_sub_id <= sub_id_r;
        end
    end

endmodule

/* l2_subsystem_top.sv */
// L1 to L2 request path with arbiter, two queues and the memory backend
// Requests must be held until ack; ack is a one-cycle pulse
// Read latency depends on queue occupancy, data_valid marks each word
`timescale 1ns/1ps

module l2_subsystem_top
    import l2_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  l1_request_t [L1_CONNECTIONS-1:0] l1_req,
    input  logic [L1_CONNECTIONS-1:0]        request,
    output logic [L1_CONNECTIONS-1:0]        ack,
    output logic [XLEN-1:0]                  l1_rd_data,
    output logic [L1_CONNECTIONS-1:0]        data_valid
);

    // Arbiter to queues
    logic req_push;
    logic wr_push;
    l2_request_t l2_req;
    l2_wr_data_t wr_data;
    logic req_full;
    logic data_full;

    // Queues to backend
    l2_request_t req_head;
    l2_wr_data_t wr_head;
    logic req_empty;
    logic req_pop;
    logic wr_pop;

    // Return path
    logic rd_valid;
    logic [XLEN-1:0] rd_data;
    logic [L2_SUB_ID_W-1:0] rd_sub_id;

    l1_arbiter u_arbiter (
        .l1_req     (l1_req),
        .request    (request),
        .ack        (ack),
        .req_full   (req_full),
        .data_full  (data_full),
        .req_push   (req_push),
        .l2_req     (l2_req),
        .wr_push    (wr_push),
        .wr_data    (wr_data),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_sub_id  (rd_sub_id),
        .l1_rd_data (l1_rd_data),
        .data_valid (data_valid)
    );

    //////////////////////////////
    // Request and write-data queues
    l2_fifo #(.WIDTH($bits(l2_request_t)), .DEPTH(REQ_FIFO_DEPTH)) u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (req_push),
        .push_data (l2_req),
        .pop       (req_pop),
        .head_data (req_head),
        .full      (req_full),
        .empty     (req_empty)
    );

    // Backend pops data only together with a write request
    l2_fifo #(.WIDTH($bits(l2_wr_data_t)), .DEPTH(DATA_FIFO_DEPTH)) u_wr_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (wr_push),
        .push_data (wr_data),
        .pop       (wr_pop),
        .head_data (wr_head),
        .full      (data_full),
        .empty     ()
    );

    l2_memory u_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_head  (req_head),
        .req_empty (req_empty),
        .req_pop   (req_pop),
        .wr_head   (wr_head),
        .wr_pop    (wr_pop),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_sub_id (rd_sub_id)
    );

endmodule

/* tb_checker.sv */
// Scoreboard for the L1 to L2 request path, sampled on the falling clock edge
// Memory model is updated in ack order, read words are predicted at ack time
// Assumes every word is written before it is read, the preload takes care of it
// Leftover expected words are reported when run_done rises
`timescale 1ns/1ps

module tb_checker
    import l2_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  l1_request_t [L1_CONNECTIONS-1:0] l1_req,
    input  logic [L1_CONNECTIONS-1:0]        request,
    input  logic [L1_CONNECTIONS-1:0]        ack,
    input  logic [XLEN-1:0]                  l1_rd_data,
    input  logic [L1_CONNECTIONS-1:0]        data_valid,
    input  logic                             run_done,
    output int                               error_count,
    output int                               pending
);

    // Reference memory and per-port expected read words
    logic [XLEN-1:0] model [MEM_DEPTH];
    logic [XLEN-1:0] dcache_exp [$];
    logic [XLEN-1:0] icache_exp [$];
    int ack_count;
    int word_count;
    logic first_after_reset;

    initial begin
        error_count = 0;
        pending = 0;
        ack_count = 0;
        word_count = 0;
        first_after_reset = 1'b0;
    end

    function automatic int expected_count(input int p);
        return (p == L1_DCACHE_ID) ? dcache_exp.size() : icache_exp.size();
    endfunction

    task automatic push_expected(input int p, input logic [XLEN-1:0] word);
        if (p == L1_DCACHE_ID) begin
            dcache_exp.push_back(word);
        end else begin
            icache_exp.push_back(word);
        end
    endtask

    //////////////////////////////
    // Reset quiet check
    task automatic check_idle(input string phase);
        if (ack !== '0) begin
            $display("error: time %0t, signal ack %s, got %b, expected %b",
                     $time, phase, ack, L1_CONNECTIONS'(0));
            error_count++;
        end
        if (data_valid !== '0) begin
            $display("error: time %0t, signal data_valid %s, got %b, expected %b",
                     $time, phase, data_valid, L1_CONNECTIONS'(0));
            error_count++;
        end
    endtask

    //////////////////////////////
    // Ack rules and model update
    task automatic check_acks();
        int p;
        logic [MEM_ADDR_W-1:0] idx;
        l1_request_t r;
        if ($countones(ack) > 1) begin
            $display("more than one ack bit set at time %0t, ack %b", $time, ack);
            error_count++;
        end
        if ((ack & ~request) != '0) begin
            $display("ack given to a port without a request at time %0t", $time);
            error_count++;
        end
        // Dcache wins when both ask
        if ((&request) && ack != '0 && ack != (1 << L1_DCACHE_ID)) begin
            $display("error: time %0t, signal ack, got %b, expected %b",
                     $time, ack, L1_CONNECTIONS'(1 << L1_DCACHE_ID));
            error_count++;
        end
        if ($countones(ack) == 1) begin
            p = ack[L1_DCACHE_ID] ? L1_DCACHE_ID : L1_ICACHE_ID;
            r = l1_req[p];
            idx = r.addr[MEM_ADDR_W+1:2];
            ack_count++;
            if (!r.rnw) begin
                // Merge enabled bytes only
                for (int b = 0; b < BE_W; b++) begin
                    if (r.be[b]) begin
                        model[idx][b*8 +: 8] = r.data[b*8 +: 8];
                    end
                end
            end else begin
                // Burst wraps inside the array
                for (int w = 0; w <= int'(r.size); w++) begin
                    push_expected(p, model[idx]);
                    idx = idx + 1'b1;
                end
            end
        end
    endtask

    //////////////////////////////
    // Returned words
    task automatic compare_word(input int p);
        logic [XLEN-1:0] exp;
        if (expected_count(p) == 0) begin
            $display("read word returned to port %0d with no read outstanding at time %0t",
                     p, $time);
            error_count++;
        end else begin
            exp = (p == L1_DCACHE_ID) ? dcache_exp.pop_front() : icache_exp.pop_front();
            word_count++;
            if (l1_rd_data !== exp) begin
                $display("error: time %0t, signal l1_rd_data port %0d, got %h, expected %h",
                         $time, p, l1_rd_data, exp);
                error_count++;
            end
        end
    endtask

    task automatic check_returns();
        if (&data_valid) begin
            $display("data_valid raised for both ports at once at time %0t", $time);
            error_count++;
        end
        for (int p = 0; p < L1_CONNECTIONS; p++) begin
            if (data_valid[p]) begin
                compare_word(p);
            end
        end
    endtask

    // Inputs settle 1 ns after the rising edge, so the falling edge is safe
    always @(negedge clk) begin
        if (!rst_n) begin
            first_after_reset = 1'b1;
            check_idle("during reset");
        end else begin
            if (first_after_reset) begin
                check_idle("in the first cycle after reset");
                first_after_reset = 1'b0;
            end
            check_acks();
            check_returns();
        end
        pending = dcache_exp.size() + icache_exp.size();
    end

    //////////////////////////////
    // End of run
    always @(posedge run_done) begin
        for (int p = 0; p < L1_CONNECTIONS; p++) begin
            if (expected_count(p) != 0) begin
                $display("missing response: port %0d still expects %0d read words",
                         p, expected_count(p));
                error_count++;
            end
        end
        $display("summary: %0d acks, %0d read words compared, %0d errors",
                 ack_count, word_count, error_count);
    end

endmodule

/* tb_top.sv */
// Random traffic on both L1 ports against the L2 request path
// Preload writes every word first, so all later reads have known data
// Inputs change 1 ns after the rising edge and are held until ack
`timescale 1ns/1ps

module tb_top
    import l2_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_CYCLES = 2000;
    // Worst case per request is a 4-word read behind a full queue
    localparam int MAX_REQUESTS = MEM_DEPTH + RAND_CYCLES;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_REQUESTS * 8 + 200;
    localparam int DRAIN_LIMIT = REQ_FIFO_DEPTH * 8 + 16;

    // Starts low without an edge at time zero
    logic clk = 1'b0;
    logic rst_n;
    l1_request_t [L1_CONNECTIONS-1:0] l1_req;
    logic [L1_CONNECTIONS-1:0] request;
    logic [L1_CONNECTIONS-1:0] ack;
    logic [XLEN-1:0] l1_rd_data;
    logic [L1_CONNECTIONS-1:0] data_valid;
    logic run_done;
    int error_count;
    int pending;
    integer seed;

    l2_subsystem_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .l1_req     (l1_req),
        .request    (request),
        .ack        (ack),
        .l1_rd_data (l1_rd_data),
        .data_valid (data_valid)
    );

    tb_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .l1_req      (l1_req),
        .request     (request),
        .ack         (ack),
        .l1_rd_data  (l1_rd_data),
        .data_valid  (data_valid),
        .run_done    (run_done),
        .error_count (error_count),
        .pending     (pending)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Stimulus helpers
    // Icache only reads, dcache mixes reads and byte-enabled writes
    task automatic new_request(input int p);
        logic [31:0] rnd;
        logic [31:0] addr_rnd;
        rnd = $random(seed);
        addr_rnd = $random(seed);
        l1_req[p].addr = {addr_rnd[XLEN-1:2], 2'b00};
        l1_req[p].rnw = (p == L1_ICACHE_ID) ? 1'b1 : rnd[0];
        l1_req[p].size = rnd[2:1];
        l1_req[p].data = $random(seed);
        l1_req[p].be = rnd[6:3];
        request[p] = 1'b1;
    endtask

    // One clock: sample ack before the edge, then update each port
    task automatic step_ports(input bit allow_new);
        logic [L1_CONNECTIONS-1:0] acked;
        logic [31:0] rnd;
        @(negedge clk);
        acked = ack;
        @(posedge clk);
        #1;
        for (int p = 0; p < L1_CONNECTIONS; p++) begin
            if (acked[p] || !request[p]) begin
                rnd = $random(seed);
                // Busy ports, three requests in four cycles
                if (allow_new && rnd[1:0] != 2'b00) begin
                    new_request(p);
                end else begin
                    request[p] = 1'b0;
                end
            end
        end
    endtask

    // Full-word writes to every address, back to back
    task automatic preload_memory();
        logic [L1_CONNECTIONS-1:0] acked;
        for (int w = 0; w < MEM_DEPTH; w++) begin
            l1_req[L1_DCACHE_ID].addr = XLEN'(w) << 2;
            l1_req[L1_DCACHE_ID].rnw = 1'b0;
            l1_req[L1_DCACHE_ID].size = '0;
            l1_req[L1_DCACHE_ID].data = $random(seed);
            l1_req[L1_DCACHE_ID].be = '1;
            request[L1_DCACHE_ID] = 1'b1;
            do begin
                @(negedge clk);
                acked = ack;
                @(posedge clk);
                #1;
            end while (!acked[L1_DCACHE_ID]);
        end
        request[L1_DCACHE_ID] = 1'b0;
    endtask

    //////////////////////////////
    // Main sequence
    initial begin
        int drain;
        seed = 36;
        rst_n = 1'b0;
        request = '0;
        l1_req = '0;
        run_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // First cycle after reset stays quiet
        @(posedge clk);
        #1;
        preload_memory();
        repeat (RAND_CYCLES) step_ports(1'b1);
        // Held requests still need their acks
        while (request != '0) begin
            step_ports(1'b0);
        end
        for (drain = 0; drain < DRAIN_LIMIT && pending != 0; drain++) begin
            @(posedge clk);
        end
        run_done = 1'b1;
        #1;
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout: run did not end within %0d cycles, %0d read words pending",
                 WATCHDOG_CYCLES, pending);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* sim.f */
l2_pkg.sv
priority_encoder.sv
l2_fifo.sv
l1_arbiter.sv
l2_memory.sv
l2_subsystem_top.sv
tb_checker.sv
tb_top.sv
